//--- mem_arb_macros.svh
`ifndef MEM_ARB_MACROS_SVH
`define MEM_ARB_MACROS_SVH

// Matching queue size and its pointer width
`define MEM_QUEUE_DEPTH 16
`define MEM_QUEUE_DEPTH_N 4

// Access time of the backing memory in cycles
`define MEM_LATENCY 3

// Word index bits, 256 words
`define MEM_WORDS_N 8

// Instruction fetches always read a full doubleword
`define INST_ORDER 2'h2
`define INST_MASK 4'hf

`endif

//--- mem_arb_pkg.sv
`default_nettype none

package mem_arb_pkg;

	// Vector types with a meaning of their own
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [13:0] tid_t;
	typedef logic [31:0] pdt_t;
	typedef logic [23:0] mmu_flags_t;
	typedef logic [3:0] byte_mask_t;

	// One request on the shared memory port
	typedef struct packed {
		logic [1:0] order;
		byte_mask_t mask;
		// 1 for a store
		logic rw;
		// Data store, answered without a matching entry
		logic store_ack;
		logic [1:0] mmu_mode;
		logic [2:0] mmu_ps;
		pdt_t pdt;
		tid_t tid;
		addr_t addr;
		word_t data;
	} mem_req_t;

	// Load doubleword plus request context
	typedef struct packed {
		dword_t data;
		mmu_flags_t mmu_flags;
	} mem_rsp_t;

	// Backing memory sequencing
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT,
		MEM_RESPOND
	} mem_state_t;

endpackage

`default_nettype wire

//--- arbiter_matching_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_arb_macros.svh"

module arbiter_matching_queue #(
	parameter int DEPTH = `MEM_QUEUE_DEPTH,
	parameter int DEPTH_N = `MEM_QUEUE_DEPTH_N
) (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic wr_req,
	input wire logic wr_flag,
	output logic wr_full,
	input wire logic rd_req,
	output logic rd_valid,
	output logic rd_flag
);

	// Extra top bit tells a full buffer from an empty one
	logic [DEPTH_N:0] wr_ptr;
	logic [DEPTH_N:0] rd_ptr;
	logic [DEPTH-1:0] flags;
	logic push;
	logic pop;

	function automatic logic [DEPTH_N:0] next_ptr(input logic [DEPTH_N:0] ptr);
		if (ptr[DEPTH_N-1:0] == DEPTH_N'(DEPTH - 1)) begin
			return {~ptr[DEPTH_N], {DEPTH_N{1'b0}}};
		end
		return ptr + 1'b1;
	endfunction

	assign wr_full = (wr_ptr[DEPTH_N] != rd_ptr[DEPTH_N]) &&
		(wr_ptr[DEPTH_N-1:0] == rd_ptr[DEPTH_N-1:0]);
	assign rd_valid = (wr_ptr != rd_ptr);
	assign rd_flag = flags[rd_ptr[DEPTH_N-1:0]];

	assign push = wr_req && !wr_full;
	assign pop = rd_req && rd_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
		end
	end

	// 0 marks an instruction entry, 1 a data entry
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			flags[wr_ptr[DEPTH_N-1:0]] <= wr_flag;
		end
	end

endmodule

`default_nettype wire

//--- memory_pipe_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_arb_macros.svh"

module memory_pipe_arbiter (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Data port
	input wire logic data_req,
	output logic data_lock,
	input wire logic [1:0] data_order,
	input wire mem_arb_pkg::byte_mask_t data_mask,
	input wire logic data_rw,
	input wire mem_arb_pkg::tid_t data_tid,
	input wire logic [1:0] data_mmu_mode,
	input wire logic [2:0] data_mmu_ps,
	input wire mem_arb_pkg::pdt_t data_pdt,
	input wire mem_arb_pkg::addr_t data_addr,
	input wire mem_arb_pkg::word_t data_data,
	output logic data_valid,
	input wire logic data_busy,
	output mem_arb_pkg::mem_rsp_t data_rsp,
	// Instruction port
	input wire logic inst_req,
	output logic inst_lock,
	input wire logic [1:0] inst_mmu_mode,
	input wire logic [2:0] inst_mmu_ps,
	input wire mem_arb_pkg::pdt_t inst_pdt,
	input wire mem_arb_pkg::tid_t inst_tid,
	input wire mem_arb_pkg::addr_t inst_addr,
	output logic inst_valid,
	input wire logic inst_busy,
	output mem_arb_pkg::mem_rsp_t inst_rsp,
	// Memory side
	output logic mem_req,
	input wire logic mem_lock,
	output mem_arb_pkg::mem_req_t mem_req_bus,
	input wire logic mem_valid,
	output logic mem_busy,
	input wire logic mem_store_ack,
	input wire mem_arb_pkg::mem_rsp_t mem_rsp_bus
);

	import mem_arb_pkg::*;

	logic q_full;
	logic q_rd_valid;
	logic q_rd_flag;
	logic common_lock;
	logic data_cond;
	logic inst_cond;
	logic q_push;
	logic q_pop;
	mem_req_t next_req;
	logic req_r;
	mem_req_t req_bus_r;
	logic inst_valid_r;
	mem_rsp_t inst_rsp_r;
	logic data_valid_r;
	mem_rsp_t data_rsp_r;

	// Data side has priority
	assign data_cond = data_req;
	assign inst_cond = !data_req && inst_req;

	assign common_lock = q_full || mem_lock;
	assign inst_lock = common_lock || data_cond;
	assign data_lock = common_lock || inst_cond;

	// Stores bypass the queue, their ack is routed by store_ack
	assign q_push = !common_lock && ((data_cond && !data_rw) || inst_cond);
	assign q_pop = mem_valid && !mem_store_ack;

	arbiter_matching_queue #(
		.DEPTH(`MEM_QUEUE_DEPTH),
		.DEPTH_N(`MEM_QUEUE_DEPTH_N)
	) matching_queue0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wr_req(q_push),
		.wr_flag(data_cond),
		.wr_full(q_full),
		.rd_req(q_pop),
		.rd_valid(q_rd_valid),
		.rd_flag(q_rd_flag)
	);

	always_comb begin
		next_req = '0;
		if (data_cond) begin
			next_req.order = data_order;
			next_req.mask = data_mask;
			next_req.rw = data_rw;
			next_req.store_ack = data_rw;
			next_req.mmu_mode = data_mmu_mode;
			next_req.mmu_ps = data_mmu_ps;
			next_req.pdt = data_pdt;
			next_req.tid = data_tid;
			next_req.addr = data_addr;
			next_req.data = data_data;
		end else begin
			// Fetch is a plain full-width load
			next_req.order = `INST_ORDER;
			next_req.mask = `INST_MASK;
			next_req.mmu_mode = inst_mmu_mode;
			next_req.mmu_ps = inst_mmu_ps;
			next_req.pdt = inst_pdt;
			next_req.tid = inst_tid;
			next_req.addr = inst_addr;
		end
	end

	// Held unchanged while the common lock is up
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_r <= 1'b0;
		end else if (!common_lock) begin
			req_r <= data_cond || inst_cond;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!common_lock && (data_cond || inst_cond)) begin
			req_bus_r <= next_req;
		end
	end

	// Response valids steered by the queue head
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inst_valid_r <= 1'b0;
			data_valid_r <= 1'b0;
		end else begin
			if (!inst_busy) begin
				inst_valid_r <= mem_valid && !mem_store_ack && q_rd_valid && !q_rd_flag;
			end
			data_valid_r <= mem_valid && (mem_store_ack || (q_rd_valid && q_rd_flag));
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (mem_valid && !inst_busy) begin
			inst_rsp_r <= mem_rsp_bus;
		end
		if (mem_valid) begin
			data_rsp_r <= mem_rsp_bus;
		end
	end

	assign mem_req = req_r;
	assign mem_req_bus = req_bus_r;
	assign mem_busy = data_busy || inst_busy;

	assign inst_valid = inst_valid_r && !inst_busy;
	assign inst_rsp = inst_rsp_r;
	assign data_valid = data_valid_r;
	assign data_rsp = data_rsp_r;

endmodule

`default_nettype wire

//--- mem_latency_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_arb_macros.svh"

module mem_latency_timer (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic start,
	output logic done
);

	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	logic [CNT_W-1:0] count;
	logic running;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
			running <= 1'b0;
		end else if (start) begin
			count <= CNT_W'(`MEM_LATENCY);
			running <= 1'b1;
		end else if (running) begin
			if (count == '0) begin
				running <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Single cycle at the end of the access time
	assign done = running && (count == '0);

endmodule

`default_nettype wire

//--- mem_access_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_fsm (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic mem_req,
	input wire logic mem_busy,
	input wire logic timer_done,
	output logic accept,
	output logic timer_start,
	output logic mem_lock,
	output logic mem_valid
);

	import mem_arb_pkg::*;

	mem_state_t state;
	mem_state_t next_state;

	// Only one request in flight
	assign accept = (state == MEM_IDLE) && mem_req;
	assign timer_start = accept;
	assign mem_lock = (state != MEM_IDLE);

	// Response waits here until the core side can take it
	assign mem_valid = (state == MEM_RESPOND) && !mem_busy;

	always_comb begin
		next_state = state;
		case (state)
			MEM_IDLE: begin
				if (accept) begin
					next_state = MEM_WAIT;
				end
			end
			MEM_WAIT: begin
				if (timer_done) begin
					next_state = MEM_RESPOND;
				end
			end
			MEM_RESPOND: begin
				if (mem_valid) begin
					next_state = MEM_IDLE;
				end
			end
			default: begin
				next_state = MEM_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= MEM_IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

//--- mem_backing_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_arb_macros.svh"

module mem_backing_store (
	input wire logic iCLOCK,
	input wire logic accept,
	input wire mem_arb_pkg::mem_req_t mem_req_bus,
	output logic mem_store_ack,
	output mem_arb_pkg::mem_rsp_t mem_rsp_bus
);

	import mem_arb_pkg::*;

	word_t mem [0:(2**`MEM_WORDS_N)-1];
	logic [`MEM_WORDS_N-1:0] word_idx;
	logic [`MEM_WORDS_N-2:0] pair_idx;

	assign word_idx = mem_req_bus.addr[`MEM_WORDS_N+1:2];
	assign pair_idx = word_idx[`MEM_WORDS_N-1:1];

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			if (mem_req_bus.rw) begin
				for (int i = 0; i < 4; i++) begin
					if (mem_req_bus.mask[i]) begin
						mem[word_idx][i*8 +: 8] <= mem_req_bus.data[i*8 +: 8];
					end
				end
			end else begin
				// Odd word lands in the upper half
				mem_rsp_bus.data <= {mem[{pair_idx, 1'b1}], mem[{pair_idx, 1'b0}]};
			end
			mem_store_ack <= mem_req_bus.store_ack;
			// No translation, flags just echo the context
			mem_rsp_bus.mmu_flags <= {5'b0, mem_req_bus.tid, mem_req_bus.mmu_mode,
				mem_req_bus.mmu_ps};
		end
	end

endmodule

`default_nettype wire

//--- memory_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

module memory_pipe_top (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Data port
	input wire logic data_req,
	output logic data_lock,
	input wire logic [1:0] data_order,
	input wire mem_arb_pkg::byte_mask_t data_mask,
	input wire logic data_rw,
	input wire mem_arb_pkg::tid_t data_tid,
	input wire logic [1:0] data_mmu_mode,
	input wire logic [2:0] data_mmu_ps,
	input wire mem_arb_pkg::pdt_t data_pdt,
	input wire mem_arb_pkg::addr_t data_addr,
	input wire mem_arb_pkg::word_t data_data,
	output logic data_valid,
	input wire logic data_busy,
	output mem_arb_pkg::mem_rsp_t data_rsp,
	// Instruction port
	input wire logic inst_req,
	output logic inst_lock,
	input wire logic [1:0] inst_mmu_mode,
	input wire logic [2:0] inst_mmu_ps,
	input wire mem_arb_pkg::pdt_t inst_pdt,
	input wire mem_arb_pkg::tid_t inst_tid,
	input wire mem_arb_pkg::addr_t inst_addr,
	output logic inst_valid,
	input wire logic inst_busy,
	output mem_arb_pkg::mem_rsp_t inst_rsp
);

	import mem_arb_pkg::*;

	logic mem_req;
	mem_req_t mem_req_bus;
	logic mem_busy;
	logic mem_lock;
	logic mem_valid;
	logic mem_store_ack;
	mem_rsp_t mem_rsp_bus;
	logic accept;
	logic timer_start;
	logic timer_done;

	memory_pipe_arbiter arbiter0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_order(data_order),
		.data_mask(data_mask),
		.data_rw(data_rw),
		.data_tid(data_tid),
		.data_mmu_mode(data_mmu_mode),
		.data_mmu_ps(data_mmu_ps),
		.data_pdt(data_pdt),
		.data_addr(data_addr),
		.data_data(data_data),
		.data_valid(data_valid),
		.data_busy(data_busy),
		.data_rsp(data_rsp),
		.inst_req(inst_req),
		.inst_lock(inst_lock),
		.inst_mmu_mode(inst_mmu_mode),
		.inst_mmu_ps(inst_mmu_ps),
		.inst_pdt(inst_pdt),
		.inst_tid(inst_tid),
		.inst_addr(inst_addr),
		.inst_valid(inst_valid),
		.inst_busy(inst_busy),
		.inst_rsp(inst_rsp),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_req_bus(mem_req_bus),
		.mem_valid(mem_valid),
		.mem_busy(mem_busy),
		.mem_store_ack(mem_store_ack),
		.mem_rsp_bus(mem_rsp_bus)
	);

	mem_access_fsm fsm0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_req(mem_req),
		.mem_busy(mem_busy),
		.timer_done(timer_done),
		.accept(accept),
		.timer_start(timer_start),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid)
	);

	mem_latency_timer timer0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.start(timer_start),
		.done(timer_done)
	);

	mem_backing_store store0 (
		.iCLOCK(iCLOCK),
		.accept(accept),
		.mem_req_bus(mem_req_bus),
		.mem_store_ack(mem_store_ack),
		.mem_rsp_bus(mem_rsp_bus)
	);

endmodule

`default_nettype wire

//--- tb_memory_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memory_pipe;

	import mem_arb_pkg::*;

	localparam int TIMEOUT = 2000;
	localparam int NUM_WORDS = 32;

	logic iCLOCK;
	logic inRESET;
	logic data_req;
	logic data_lock;
	logic [1:0] data_order;
	byte_mask_t data_mask;
	logic data_rw;
	tid_t data_tid;
	logic [1:0] data_mmu_mode;
	logic [2:0] data_mmu_ps;
	pdt_t data_pdt;
	addr_t data_addr;
	word_t data_data;
	logic data_valid;
	logic data_busy;
	mem_rsp_t data_rsp;
	logic inst_req;
	logic inst_lock;
	logic [1:0] inst_mmu_mode;
	logic [2:0] inst_mmu_ps;
	pdt_t inst_pdt;
	tid_t inst_tid;
	addr_t inst_addr;
	logic inst_valid;
	logic inst_busy;
	mem_rsp_t inst_rsp;

	integer seed;
	int mismatch_count;
	int other_count;
	int busy_cycles;
	logic mix_done;
	logic exp_is_store;
	mem_rsp_t exp_d;
	mem_rsp_t exp_i;

	// Mirror of the backing memory by word index
	word_t ref_mem [0:255];
	mem_rsp_t exp_data_q[$];
	logic exp_store_q[$];
	mem_rsp_t exp_inst_q[$];

	memory_pipe_top dut0 (.*);

	always #50 iCLOCK = ~iCLOCK;

	function automatic void mirror_store(input addr_t addr, input word_t data,
		input byte_mask_t mask);
		for (int i = 0; i < 4; i++) begin
			if (mask[i]) begin
				ref_mem[addr[9:2]][i*8 +: 8] = data[i*8 +: 8];
			end
		end
	endfunction

	// Aligned word pair with the request context in the low 19 flag bits
	function automatic mem_rsp_t expected_rsp(input addr_t addr, input tid_t tid,
		input logic [1:0] mode, input logic [2:0] ps);
		mem_rsp_t rsp;
		logic [7:0] idx;
		idx = {addr[9:3], 1'b0};
		rsp.data = {ref_mem[idx + 8'd1], ref_mem[idx]};
		rsp.mmu_flags = {5'b0, tid, mode, ps};
		return rsp;
	endfunction

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// Request is taken at the first rising edge with its lock low
	task automatic wait_taken(input logic is_data);
		int waited;
		logic lock_seen;
		waited = 0;
		lock_seen = 1'b1;
		while (lock_seen) begin
			@(negedge iCLOCK);
			lock_seen = is_data ? data_lock : inst_lock;
			@(posedge iCLOCK);
			waited++;
			if (waited > TIMEOUT) begin
				other_count++;
				$display("timeout: %s request was never taken", is_data ? "data" : "fetch");
				finish_run();
			end
		end
	endtask

	task automatic data_access(input logic rw, input addr_t addr, input word_t wdata,
		input byte_mask_t mask);
		tid_t tid;
		logic [1:0] mode;
		logic [2:0] ps;
		mem_rsp_t rsp;
		tid = 14'($random(seed));
		mode = 2'($random(seed));
		ps = 3'($random(seed));
		data_req = 1'b1;
		data_rw = rw;
		data_order = 2'h2;
		data_mask = mask;
		data_tid = tid;
		data_mmu_mode = mode;
		data_mmu_ps = ps;
		data_pdt = 32'($random(seed));
		data_addr = addr;
		data_data = wdata;
		wait_taken(1'b1);
		// Model updated in the order the memory sees requests
		if (rw) begin
			mirror_store(addr, wdata, mask);
			rsp.data = '0;
			rsp.mmu_flags = {5'b0, tid, mode, ps};
		end else begin
			rsp = expected_rsp(addr, tid, mode, ps);
		end
		exp_data_q.push_back(rsp);
		exp_store_q.push_back(rw);
		#1;
		data_req = 1'b0;
	endtask

	task automatic inst_fetch(input addr_t addr);
		tid_t tid;
		logic [1:0] mode;
		logic [2:0] ps;
		tid = 14'($random(seed));
		mode = 2'($random(seed));
		ps = 3'($random(seed));
		inst_req = 1'b1;
		inst_addr = addr;
		inst_tid = tid;
		inst_mmu_mode = mode;
		inst_mmu_ps = ps;
		inst_pdt = 32'($random(seed));
		wait_taken(1'b0);
		exp_inst_q.push_back(expected_rsp(addr, tid, mode, ps));
		#1;
		inst_req = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 || exp_inst_q.size() != 0) begin
			@(posedge iCLOCK);
			waited++;
			if (waited > TIMEOUT) begin
				other_count++;
				$display("timeout: %0d data and %0d fetch responses never arrived",
					exp_data_q.size(), exp_inst_q.size());
				finish_run();
			end
		end
		@(posedge iCLOCK);
		#1;
	endtask

	task automatic random_data_ops(input int count);
		logic rw;
		addr_t addr;
		for (int n = 0; n < count; n++) begin
			rw = 1'($random(seed));
			addr = {25'b0, 5'($random(seed)), 2'b00};
			data_access(rw, addr, word_t'($random(seed)), 4'($random(seed)));
			repeat (2'($random(seed))) begin
				@(posedge iCLOCK);
				#1;
			end
		end
	endtask

	task automatic random_fetches(input int count);
		for (int n = 0; n < count; n++) begin
			inst_fetch({25'b0, 5'($random(seed)), 2'b00});
			repeat (2'($random(seed))) begin
				@(posedge iCLOCK);
				#1;
			end
		end
	endtask

	// Response checker sampling mid-cycle
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			if (data_req && !inst_lock) begin
				other_count++;
				$display("inst_lock was low while data_req was high");
			end
			if (inst_busy && inst_valid) begin
				other_count++;
				$display("inst_valid was given while inst_busy was high");
			end
			if (data_valid) begin
				if (exp_data_q.size() == 0) begin
					other_count++;
					$display("data_valid came with no data request outstanding");
				end else begin
					exp_d = exp_data_q.pop_front();
					exp_is_store = exp_store_q.pop_front();
					if (!exp_is_store && data_rsp.data !== exp_d.data) begin
						mismatch_count++;
						$display("mismatch data_rsp.data got %h expected %h",
							data_rsp.data, exp_d.data);
					end
					if (data_rsp.mmu_flags !== exp_d.mmu_flags) begin
						mismatch_count++;
						$display("mismatch data_rsp.mmu_flags got %h expected %h",
							data_rsp.mmu_flags, exp_d.mmu_flags);
					end
				end
			end
			if (inst_valid) begin
				if (exp_inst_q.size() == 0) begin
					other_count++;
					$display("inst_valid came with no fetch outstanding");
				end else begin
					exp_i = exp_inst_q.pop_front();
					if (inst_rsp !== exp_i) begin
						mismatch_count++;
						$display("mismatch inst_rsp got %h expected %h", inst_rsp, exp_i);
					end
				end
			end
		end
	end

	initial begin
		seed = 18044;
		mismatch_count = 0;
		other_count = 0;
		mix_done = 1'b0;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		data_req = 1'b0;
		data_order = 2'h0;
		data_mask = '0;
		data_rw = 1'b0;
		data_tid = '0;
		data_mmu_mode = '0;
		data_mmu_ps = '0;
		data_pdt = '0;
		data_addr = '0;
		data_data = '0;
		data_busy = 1'b0;
		inst_req = 1'b0;
		inst_mmu_mode = '0;
		inst_mmu_ps = '0;
		inst_pdt = '0;
		inst_tid = '0;
		inst_addr = '0;
		inst_busy = 1'b0;
		repeat (4) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		if (data_valid || inst_valid) begin
			other_count++;
			$display("a response valid was high right after reset");
		end
		// Fill the test range and read every pair back
		for (int i = 0; i < NUM_WORDS; i++) begin
			data_access(1'b1, addr_t'(i * 4), word_t'($random(seed)), 4'hf);
		end
		wait_drain();
		for (int i = 0; i < NUM_WORDS; i += 2) begin
			data_access(1'b0, addr_t'(i * 4), '0, 4'hf);
		end
		wait_drain();
		// Bytes 0 and 2 only
		data_access(1'b1, 32'h14, 32'ha5c3_96f0, 4'b0101);
		data_access(1'b0, 32'h14, '0, 4'hf);
		wait_drain();
		for (int i = 0; i < NUM_WORDS; i += 4) begin
			inst_fetch(addr_t'(i * 4));
		end
		wait_drain();
		// Both ports asking at once
		fork
			for (int i = 0; i < 4; i++) begin
				data_access(i[0], addr_t'(i * 8 + 4), word_t'($random(seed)), 4'hf);
			end
			for (int i = 0; i < 2; i++) begin
				inst_fetch(addr_t'(i * 8));
			end
		join
		wait_drain();
		// Fetches under long busy stretches
		fork
			for (int i = 0; i < 4; i++) begin
				inst_fetch(addr_t'(i * 4 + 32));
			end
			repeat (3) begin
				inst_busy = 1'b1;
				repeat (12) @(posedge iCLOCK);
				#1;
				// One free cycle lets a response in, and busy then holds it
				inst_busy = 1'b0;
				@(posedge iCLOCK);
				#1;
			end
		join
		wait_drain();
		fork
			begin
				fork
					random_data_ops(40);
					random_fetches(30);
				join
				mix_done = 1'b1;
			end
			begin
				busy_cycles = 0;
				while (!mix_done && busy_cycles < TIMEOUT) begin
					data_busy = ($random(seed) & 3) == 0;
					inst_busy = ($random(seed) & 3) == 0;
					@(posedge iCLOCK);
					#1;
					busy_cycles++;
				end
				data_busy = 1'b0;
				inst_busy = 1'b0;
			end
		join
		wait_drain();
		finish_run();
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
mem_arb_pkg.sv
arbiter_matching_queue.sv
memory_pipe_arbiter.sv
mem_latency_timer.sv
mem_access_fsm.sv
mem_backing_store.sv
memory_pipe_top.sv
tb_memory_pipe.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing
TOP = tb_memory_pipe
FILELIST = src.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
